// File: hw/cpu_pkg.sv
package cpu_pkg;

    //////////////////// widths
    localparam int word_w   = 16;              // data and address width
    localparam int reg_id_w = 4;               // register index width
    localparam int num_regs = 2 ** reg_id_w;   // r0..r15
    localparam int shamt_w  = 4;               // shift amount, low imm bits

    typedef logic [word_w-1:0]   word_t;
    typedef logic [reg_id_w-1:0] reg_id_t;

    //////////////////// instruction set
    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_xor = 4'h2,
        op_sll = 4'h4,
        op_sra = 4'h5,
        op_ror = 4'h6,
        op_lw  = 4'h8,
        op_sw  = 4'h9,
        op_llb = 4'ha,
        op_lhb = 4'hb,
        op_hlt = 4'hf
    } opcode_t;                                // unlisted codes run as no-ops

    localparam word_t nop_instr = 16'h3000;    // opcode 3, fed in once halted

    // register view; rt doubles as a 4 bit imm for shifts and LW/SW
    typedef struct packed {
        opcode_t opcode;
        reg_id_t rd;
        reg_id_t rs;
        reg_id_t rt;
    } instr_reg_t;

    // byte view for LLB/LHB
    typedef struct packed {
        opcode_t    opcode;
        reg_id_t    rd;
        logic [7:0] imm8;
    } instr_byte_t;

    typedef union packed {
        instr_reg_t  r;
        instr_byte_t b;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_xor = 3'd2,
        alu_sll = 3'd4,
        alu_sra = 3'd5,
        alu_ror = 3'd6
    } alu_op_t;

    //////////////////// pipeline registers
    typedef struct packed {
        logic   valid;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        reg_id_t    rs_id;      // after register select
        reg_id_t    rt_id;
        word_t      rs_data;
        word_t      rt_data;
        reg_id_t    rd;
        word_t      imm;        // sign extended
        logic [7:0] load_byte;
        alu_op_t    alu_op;
        logic       alu_src;    // 1: imm as operand b
        logic       mem_read;
        logic       mem_write;
        logic       lb_mode;    // 1: LHB, 0: LLB
        logic       lb_sel;     // take byte merge result
        logic       reg_write;
        logic       hlt;
    } id_ex_t;

    typedef struct packed {
        logic    valid;
        reg_id_t rd;
        word_t   result;        // alu / byte result, or address for LW/SW
        word_t   store_data;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    hlt;
    } ex_mem_t;

    typedef struct packed {
        logic    valid;
        reg_id_t rd;
        word_t   result;
        logic    reg_write;
        logic    hlt;
    } mem_wb_t;

endpackage

// File: hw/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::reg_id_t rs_id,
    input  cpu_pkg::reg_id_t rt_id,
    input  cpu_pkg::mem_wb_t wb,        // write port from MEM/WB
    output cpu_pkg::word_t   rs_data,
    output cpu_pkg::word_t   rt_data
);
    import cpu_pkg::*;

    word_t [num_regs-1:0] regs;
    logic                 we;

    assign we = wb.valid && wb.reg_write && (wb.rd != '0);   // r0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (we) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // write in the same cycle wins over the stored value
    function automatic word_t read_port(input reg_id_t id);
        if (id == '0) return '0;
        if (we && (wb.rd == id)) return wb.result;
        return regs[id];
    endfunction

    assign rs_data = read_port(rs_id);
    assign rt_data = read_port(rt_id);

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::word_t  instr,       // imem answer for pc
    input  logic            load_stall,
    input  logic            halting,
    input  logic            mem_busy,
    output cpu_pkg::word_t  pc,
    output cpu_pkg::if_id_t if_id
);
    import cpu_pkg::*;

    word_t pc_next;
    logic  hold;

    assign pc_next = pc + word_t'(2);        // 16 bit instructions
    assign hold    = load_stall || mem_busy;

    //////////////////// pc and IF/ID
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            if_id <= '0;                     // valid low out of reset
        end else if (!hold) begin
            if (!halting) begin
                pc <= pc_next;               // frozen once HLT is in ID
            end
            if_id.valid <= 1'b1;
            // past a halt only no-ops go down the pipe
            if_id.instr <= instr_u'(halting ? nop_instr : instr);
        end
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::if_id_t  if_id,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  cpu_pkg::mem_wb_t mem_wb,
    input  cpu_pkg::word_t   rs_data,    // from register file, already bypassed
    input  cpu_pkg::word_t   rt_data,
    input  logic             mem_busy,
    output cpu_pkg::reg_id_t rs_id,
    output cpu_pkg::reg_id_t rt_id,
    output logic             load_stall,
    output logic             halting,
    output cpu_pkg::id_ex_t  id_ex
);
    import cpu_pkg::*;

    instr_u ins;
    id_ex_t ctrl;       // control part of the decode
    id_ex_t dec;        // full ID/EX next value
    logic   uses_rs;
    logic   uses_rt;
    logic   rs_from_rd;  // LLB/LHB merge into rd
    logic   rt_from_rd;  // SW stores rd

    assign ins = if_id.instr;

    //////////////////// control decode
    always_comb begin
        ctrl       = '0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        rs_from_rd = 1'b0;
        rt_from_rd = 1'b0;
        if (if_id.valid) begin
            case (ins.r.opcode)
                op_add, op_sub, op_xor: begin
                    ctrl.alu_op    = alu_op_t'(ins.r.opcode[2:0]);
                    ctrl.reg_write = 1'b1;
                    uses_rs        = 1'b1;
                    uses_rt        = 1'b1;
                end
                op_sll, op_sra, op_ror: begin
                    ctrl.alu_op    = alu_op_t'(ins.r.opcode[2:0]);
                    ctrl.alu_src   = 1'b1;               // shift by imm
                    ctrl.reg_write = 1'b1;
                    uses_rs        = 1'b1;
                end
                op_lw: begin
                    ctrl.alu_src   = 1'b1;               // address add
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    uses_rs        = 1'b1;
                end
                op_sw: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    uses_rs        = 1'b1;
                    uses_rt        = 1'b1;
                    rt_from_rd     = 1'b1;
                end
                op_llb, op_lhb: begin
                    ctrl.lb_sel    = 1'b1;
                    ctrl.lb_mode   = (ins.r.opcode == op_lhb);
                    ctrl.reg_write = 1'b1;
                    uses_rs        = 1'b1;
                    rs_from_rd     = 1'b1;
                end
                op_hlt:  ctrl.hlt = 1'b1;
                default: ctrl = '0;                      // dropped opcodes
            endcase
        end
    end

    // register select, rd takes the place of a source
    assign rs_id = rs_from_rd ? ins.r.rd : ins.r.rs;
    assign rt_id = rt_from_rd ? ins.r.rd : ins.r.rt;

    always_comb begin
        dec           = ctrl;
        dec.valid     = if_id.valid;
        dec.rs_id     = rs_id;
        dec.rt_id     = rt_id;
        dec.rs_data   = rs_data;
        dec.rt_data   = rt_data;
        dec.rd        = ins.r.rd;
        dec.imm       = {{(word_w-reg_id_w){ins.r.rt[reg_id_w-1]}}, ins.r.rt};
        dec.load_byte = ins.b.imm8;                     // byte view
    end

    //////////////////// hazards
    // LW result shows up a cycle too late for EX forwarding
    assign load_stall = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) &&
                        ((uses_rs && (rs_id == id_ex.rd)) ||
                         (uses_rt && (rt_id == id_ex.rd)));

    assign halting = ctrl.hlt || id_ex.hlt || ex_mem.hlt || mem_wb.hlt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!mem_busy) begin
            id_ex <= load_stall ? id_ex_t'('0) : dec;     // bubble on load-use
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::mem_wb_t mem_wb,
    input  logic             mem_busy,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    word_t               rs_val;      // forwarded sources
    word_t               rt_val;
    word_t               op_a;
    word_t               op_b;
    word_t               alu_res;
    word_t               lb_res;
    logic [2*word_w-1:0] rot;         // doubled word for the rotate
    logic                is_mem;

    //////////////////// forwarding
    // EX/MEM is younger, so it is checked first
    function automatic word_t fwd(input reg_id_t id, input word_t rf_val,
                                  input ex_mem_t em, input mem_wb_t mw);
        if (em.valid && em.reg_write && (em.rd != '0) && (em.rd == id)) begin
            return em.result;
        end
        if (mw.valid && mw.reg_write && (mw.rd != '0) && (mw.rd == id)) begin
            return mw.result;
        end
        return rf_val;
    endfunction

    assign rs_val = fwd(id_ex.rs_id, id_ex.rs_data, ex_mem, mem_wb);
    assign rt_val = fwd(id_ex.rt_id, id_ex.rt_data, ex_mem, mem_wb);

    //////////////////// operands and ALU
    assign is_mem = id_ex.mem_read || id_ex.mem_write;
    assign op_a   = is_mem ? {rs_val[word_w-1:1], 1'b0} : rs_val;  // word aligned base
    assign op_b   = is_mem ? (id_ex.imm << 1) :
                    id_ex.alu_src ? id_ex.imm : rt_val;
    assign rot    = {op_a, op_a} >> op_b[shamt_w-1:0];

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_res = op_a - op_b;                          // wraps
            alu_xor: alu_res = op_a ^ op_b;
            alu_sll: alu_res = op_a << op_b[shamt_w-1:0];
            alu_sra: alu_res = $signed(op_a) >>> op_b[shamt_w-1:0];
            alu_ror: alu_res = rot[word_w-1:0];                      // right rotate
            default: alu_res = op_a + op_b;                          // ADD, LW, SW
        endcase
    end

    // byte merge into the old rd value
    assign lb_res = id_ex.lb_mode ? {id_ex.load_byte, rs_val[7:0]} :
                                    {rs_val[word_w-1:8], id_ex.load_byte};

    //////////////////// EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!mem_busy) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= id_ex.lb_sel ? lb_res : alu_res;
            ex_mem.store_data <= rt_val;                             // SW data is rd
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.hlt        <= id_ex.hlt;
        end
    end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  cpu_pkg::word_t   dmem_rdata,
    input  logic             dmem_ack,
    output logic             dmem_req,
    output logic             dmem_we,
    output cpu_pkg::word_t   dmem_addr,
    output cpu_pkg::word_t   dmem_wdata,
    output logic             mem_busy,    // freezes every stage
    output logic             hlt,
    output cpu_pkg::mem_wb_t mem_wb
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_hi,     // req up, waiting for ack
        st_wait_lo      // req down, waiting for ack to fall
    } state_t;

    state_t state;
    state_t state_nxt;
    word_t  load_data;
    logic   access;

    assign access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    //////////////////// four-phase sequencer
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (access) state_nxt = st_wait_hi;
            st_wait_hi: if (dmem_ack) state_nxt = st_wait_lo;
            st_wait_lo: if (!dmem_ack) state_nxt = st_idle;   // transaction done
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= st_idle;
        else        state <= state_nxt;
    end

    // busy from entry into MEM until ack is seen low
    assign mem_busy = (state == st_idle && access) ||
                      (state == st_wait_hi) ||
                      (state == st_wait_lo && dmem_ack);

    assign dmem_req   = (state == st_wait_hi);    // one cycle after entry
    assign dmem_we    = ex_mem.mem_write;         // EX/MEM is held, so these stay stable
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (state == st_wait_hi && dmem_ack) begin
            load_data <= dmem_rdata;              // grab with ack
        end
    end

    //////////////////// MEM/WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!mem_busy) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.result    <= ex_mem.mem_read ? load_data : ex_mem.result;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.hlt       <= mem_wb.hlt || ex_mem.hlt;   // sticky until reset
        end
    end

    // sticky hlt also keeps decode halting, so pc never moves again
    assign hlt = mem_wb.hlt;

endmodule

// File: hw/cpu.sv
`timescale 1ns/100ps

module cpu (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::word_t pc,          // to instruction memory
    input  cpu_pkg::word_t instr,       // combinational answer for pc
    output logic           dmem_req,
    output logic           dmem_we,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    input  cpu_pkg::word_t dmem_rdata,
    input  logic           dmem_ack,
    output logic           hlt
);
    import cpu_pkg::*;

    //////////////////// pipeline wiring
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;      // also fed back to EX and ID
    mem_wb_t mem_wb;      // rf write port and WB forward source
    reg_id_t rs_id;
    reg_id_t rt_id;
    word_t   rs_data;
    word_t   rt_data;
    logic    load_stall;
    logic    halting;
    logic    mem_busy;

    fetch_stage i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .load_stall (load_stall),
        .halting    (halting),
        .mem_busy   (mem_busy),
        .pc         (pc),
        .if_id      (if_id)
    );

    decode_stage i_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id      (if_id),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .mem_busy   (mem_busy),
        .rs_id      (rs_id),
        .rt_id      (rt_id),
        .load_stall (load_stall),
        .halting    (halting),
        .id_ex      (id_ex)
    );

    register_file i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_id   (rs_id),
        .rt_id   (rt_id),
        .wb      (mem_wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage i_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .mem_wb   (mem_wb),
        .mem_busy (mem_busy),
        .ex_mem   (ex_mem)
    );

    memory_stage i_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_ack   (dmem_ack),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .mem_busy   (mem_busy),
        .hlt        (hlt),
        .mem_wb     (mem_wb)
    );

endmodule

// File: bench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

//////////////////// random program generator

function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
endfunction

// mostly r1..r4 so that results get reused right away
function automatic logic [3:0] pick_reg();
    if (rand_below(5) == 0) return 4'(rand_below(16));
    return 4'(1 + rand_below(4));
endfunction

// kind 1 alu and byte loads, 2 load/store heavy, 3 mixed with dropped opcodes
function automatic word_t rand_instr(input int kind);
    opcode_t    alu_ops [8] = '{op_add, op_sub, op_xor, op_sll, op_sra, op_ror,
                                op_llb, op_lhb};
    int         mem_pct;
    opcode_t    op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    mem_pct = (kind == 2) ? 70 : (kind == 3) ? 30 : 0;
    if (kind == 3 && rand_below(20) == 0) begin
        return {4'hc, 12'(rand_below(4096))};       // dropped opcode, runs as no-op
    end
    if (rand_below(100) < mem_pct) op = (rand_below(2) == 0) ? op_lw : op_sw;
    else                           op = alu_ops[rand_below(8)];
    rd = pick_reg();
    rs = pick_reg();
    rt = pick_reg();
    if (op == op_llb || op == op_lhb) return {op, rd, 8'(rand_below(256))};
    if (op inside {op_sll, op_sra, op_ror, op_lw, op_sw}) begin
        rt = 4'(rand_below(16));                    // 4 bit immediate
    end
    return {op, rd, rs, rt};
endfunction

task automatic gen_program(input int kind);
    for (int i = 0; i < rom_depth; i++) rom[i] = nop_instr;
    for (int i = 0; i < 40; i++) rom[i] = rand_instr(kind);
    // dump r1..r15 through r0 base, imm r gives a distinct word each
    for (int r = 1; r < 16; r++) rom[39 + r] = {op_sw, 4'(r), 4'h0, 4'(r)};
    rom[55] = {op_hlt, 12'h000};
endtask

//////////////////// instruction level model

// fills exp_trace with {we, addr, data} for every data access in order
function automatic void run_model();
    word_t      rf [16];
    word_t      mem_wr [word_t];    // model stores laid over dmem
    word_t      ins;
    word_t      a;
    word_t      imm;
    word_t      addr;
    word_t      res;
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    logic       wr;
    exp_trace.delete();
    for (int r = 0; r < 16; r++) rf[r] = '0;
    for (int i = 0; i < rom_depth; i++) begin
        ins = rom[i];
        {op, rd, rs, rt} = ins;
        if (op == op_hlt) break;
        a    = rf[rs];
        imm  = {{12{rt[3]}}, rt};
        addr = {a[15:1], 1'b0} + (imm << 1);         // word aligned, imm in words
        res  = '0;
        wr   = 1'b1;
        case (op)
            op_add: res = a + rf[rt];
            op_sub: res = a - rf[rt];
            op_xor: res = a ^ rf[rt];
            op_sll: res = a << rt;
            op_sra: res = $signed(a) >>> rt;
            op_ror: res = (a >> rt) | (a << (16 - rt));
            op_lw: begin
                res = mem_wr.exists(addr) ? mem_wr[addr] : dmem[addr];
                exp_trace.push_back({1'b0, addr, res});
            end
            op_sw: begin
                mem_wr[addr] = rf[rd];
                exp_trace.push_back({1'b1, addr, rf[rd]});
                wr = 1'b0;
            end
            op_llb: res = {rf[rd][15:8], ins[7:0]};
            op_lhb: res = {ins[7:0], rf[rd][7:0]};
            default: wr = 1'b0;                     // no-op
        endcase
        if (wr && rd != 4'h0) rf[rd] = res;         // r0 stays zero
    end
endfunction

`endif

// File: bench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int progs_per_test = 4;
    localparam int num_progs      = 3 * progs_per_test;
    localparam int rom_depth      = 128;
    localparam int max_cycles     = 60 * 8;              // per program

    logic  clk        = 1'b0;
    logic  rst_n      = 1'b0;
    logic  dmem_ack   = 1'b0;
    word_t dmem_rdata = '0;
    word_t pc;
    word_t instr;
    logic  dmem_req;
    logic  dmem_we;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  hlt;

    integer      seed      = 32'h36b1b818;   // programs
    integer      resp_seed = 32'h36b1b818;   // memory fill and ack delays
    word_t       rom  [rom_depth];
    word_t       dmem [65536];
    logic [32:0] exp_trace [$];              // {we, addr, data}
    logic [32:0] act_trace [$];
    string       test_names [5] = '{"reset", "alu_bytes", "load_store", "handshake", "halt"};
    int          fails [5];
    int          hs_errors  = 0;             // handshake errors seen by the responder
    int          delay_left = -1;
    logic        mem_filled = 1'b0;
    logic        req_q      = 1'b0;
    logic [32:0] held       = '0;            // port values at req rise
    int          total;
    int          failed;

    `include "cpu_model.svh"

    always #2 clk = ~clk;                    // 4 ns period

    assign instr = rom[pc[7:1]];             // byte address, bit 0 ignored

    cpu dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_ack   (dmem_ack),
        .hlt        (hlt)
    );

    //////////////////// data memory responder
    always @(negedge clk) begin
        if (!rst_n) begin
            if (!mem_filled) begin
                for (int a = 0; a < 65536; a++) dmem[a] = word_t'($random(resp_seed));
                mem_filled = 1'b1;
            end
            dmem_ack   = 1'b0;
            delay_left = -1;
            req_q      = 1'b0;
        end else begin
            if (dmem_req && req_q && ({dmem_we, dmem_addr, dmem_wdata} !== held)) begin
                $display("handshake: address, write flag or write data moved while req was high");
                hs_errors++;
            end
            if (dmem_req && !req_q && dmem_ack) begin
                $display("handshake: req rose while ack was still high");
                hs_errors++;
            end
            req_q = dmem_req;
            held  = {dmem_we, dmem_addr, dmem_wdata};
            if (dmem_ack) begin
                if (!dmem_req) dmem_ack = 1'b0;          // req gone, release ack
            end else if (dmem_req) begin
                if (delay_left < 0) delay_left = $unsigned($random(resp_seed)) % 4;
                if (delay_left == 0) begin
                    if (dmem_we) dmem[dmem_addr] = dmem_wdata;
                    dmem_rdata = dmem[dmem_addr];        // write echoes its data
                    act_trace.push_back({dmem_we, dmem_addr, dmem_rdata});
                    dmem_ack   = 1'b1;
                    delay_left = -1;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    //////////////////// reporting
    task automatic report_mismatch(input int t, input string what,
                                   input logic [32:0] exp, input logic [32:0] act);
        $display("Mismatch %s %s: expected %h, actual %h", test_names[t], what, exp, act);
        fails[t]++;
    endtask

    task automatic report_failure(input int t, input string msg);
        $display("%s: %s", test_names[t], msg);
        fails[t]++;
    endtask

    task automatic print_result(input int t);
        $display("test %-10s %s, %0d errors", test_names[t], (fails[t] == 0) ? "ok" : "FAILED",
                 fails[t]);
    endtask

    //////////////////// sequences
    task automatic apply_reset(input int t);
        rst_n = 1'b0;
        repeat (16) begin
            @(negedge clk);
            if (pc !== '0) report_mismatch(t, "pc in reset", 33'd0, 33'(pc));
            if (dmem_req !== 1'b0) report_mismatch(t, "dmem_req in reset", 33'd0, 33'(dmem_req));
            if (hlt !== 1'b0) report_mismatch(t, "hlt in reset", 33'd0, 33'(hlt));
        end
        rst_n = 1'b1;
        @(negedge clk);                              // first fetch done
        if (pc !== 16'd2) report_mismatch(t, "pc after reset", 33'd2, 33'(pc));
        if (dmem_req !== 1'b0) report_mismatch(t, "dmem_req after reset", 33'd0, 33'(dmem_req));
        if (hlt !== 1'b0) report_mismatch(t, "hlt after reset", 33'd0, 33'(hlt));
    endtask

    task automatic run_program(input int t);
        int    base;
        int    cycles;
        word_t pc_hold;
        gen_program(t);
        run_model();
        base = act_trace.size();
        apply_reset(4);                              // reset must also clear a sticky hlt
        cycles = 0;
        while (hlt !== 1'b1 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (hlt !== 1'b1) report_failure(4, "hlt did not rise at the end of the program");
        if (act_trace.size() - base != exp_trace.size()) begin
            report_mismatch(t, "access count", 33'(exp_trace.size()),
                            33'(act_trace.size() - base));
        end
        for (int i = 0; i < exp_trace.size() && base + i < act_trace.size(); i++) begin
            if (act_trace[base + i] !== exp_trace[i]) begin
                report_mismatch(t, $sformatf("access %0d", i), exp_trace[i], act_trace[base + i]);
            end
        end
        // halted core sits still
        pc_hold = pc;
        repeat (20) begin
            @(negedge clk);
            if (hlt !== 1'b1) report_mismatch(4, "hlt", 33'd1, 33'(hlt));
            if (pc !== pc_hold) report_mismatch(4, "pc", 33'(pc_hold), 33'(pc));
            if (dmem_req !== 1'b0) report_failure(4, "dmem_req rose after halt");
        end
    endtask

    //////////////////// main
    initial begin
        foreach (fails[t]) fails[t] = 0;
        for (int i = 0; i < rom_depth; i++) rom[i] = nop_instr;
        apply_reset(0);
        print_result(0);
        for (int t = 1; t < 4; t++) begin
            for (int p = 0; p < progs_per_test; p++) run_program(t);
            if (t == 3) fails[3] += hs_errors;       // responder counts across all programs
            print_result(t);
        end
        print_result(4);
        total  = 0;
        failed = 0;
        foreach (fails[t]) begin
            total += fails[t];
            if (fails[t] != 0) failed++;
        end
        $display("%0d tests, %0d failed, %0d errors", 5, failed, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog, sized for the longest program
    initial begin
        #(num_progs * 60 * 8 * 4);
        $display("watchdog: run did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
hw/cpu_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu.sv
bench/tb_cpu.sv

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cpu -f files.f -o tb_cpu

out=$(./obj_dir/tb_cpu)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
